//--- include/scu_cfg.svh
`ifndef SCU_CFG_SVH
`define SCU_CFG_SVH

// CPU side
`define SCU_DATA_W     32
`define SCU_OFS_W      6

// Word offsets, byte address 0x90..0xA4
`define SCU_OFS_T0C    6'h24
`define SCU_OFS_T1S    6'h25
`define SCU_OFS_T1MD   6'h26
`define SCU_OFS_IMS    6'h28
`define SCU_OFS_IST    6'h29

// Timers
`define SCU_T0_W       10
`define SCU_T1S_W      9
`define SCU_T1MD_W     2
`define SCU_T1MD_ENB   0         // Timer enable
`define SCU_T1MD_MD    1         // Timer 1 fires only on timer 0 lines

// Interrupts
`define SCU_IRQ_W      16
`define SCU_IMS_RESET  16'hFFFF  // All sources masked
`define SCU_LEVEL_W    4
`define SCU_VEC_W      8
`define SCU_VEC_BASE   8'h40
`define SCU_EV_W       6

`endif

//--- src/scuRegPkg.sv
package scuRegPkg;

`include "scu_cfg.svh"

	typedef logic [`SCU_DATA_W-1:0] dataT;

	// One bit per byte lane
	typedef logic [`SCU_DATA_W/8-1:0] byteEnT;

	typedef logic [`SCU_OFS_W-1:0] regOfsT;

	typedef logic [`SCU_T0_W-1:0] t0CompareT;      // Scanline number
	typedef logic [`SCU_T1S_W-1:0] t1ReloadT;
	typedef logic [`SCU_T1MD_W-1:0] t1ModeT;       // Enable and line mode

endpackage

//--- src/scuIrqPkg.sv
package scuIrqPkg;

`include "scu_cfg.svh"

	typedef logic [`SCU_IRQ_W-1:0] irqVecT;
	typedef logic [`SCU_LEVEL_W-1:0] irqLevelT;    // 0 means no request
	typedef logic [`SCU_VEC_W-1:0] vecNumT;
	typedef logic [`SCU_EV_W-1:0] eventT;

	// Status and mask bit positions
	localparam int IRQ_VBIN  = 0;
	localparam int IRQ_VBOUT = 1;
	localparam int IRQ_HBIN  = 2;
	localparam int IRQ_TM0   = 3;
	localparam int IRQ_TM1   = 4;
	localparam int IRQ_SND   = 6;
	localparam int IRQ_SMPC  = 7;
	localparam int IRQ_VDP1  = 13;

	// Event pulse positions
	localparam int EV_VBIN  = 0;
	localparam int EV_VBOUT = 1;
	localparam int EV_HBIN  = 2;
	localparam int EV_SND   = 3;
	localparam int EV_VDP1  = 4;
	localparam int EV_SMPC  = 5;

endpackage

//--- src/scuEdgeDetect.sv
`timescale 1ns/1ps

module scuEdgeDetect
	import scuIrqPkg::*;
(
	input  logic  CLK,
	input  logic  RST_N,
	input  logic  vblankN,
	input  logic  hblankN,
	input  logic  soundReqN,
	input  logic  vdp1ReqN,
	input  logic  smpcReqN,
	output eventT events
);

	logic [4:0] lines;
	logic [4:0] sync1;
	logic [4:0] sync2;
	logic [4:0] prev;
	logic [4:0] fall;
	logic       rise;

	assign lines = {smpcReqN, vdp1ReqN, soundReqN, hblankN, vblankN};

	// Lines idle high
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sync1 <= '1;
			sync2 <= '1;
			prev  <= '1;
		end else begin
			sync1 <= lines;
			sync2 <= sync1;
			prev  <= sync2;
		end
	end

	assign fall = prev & ~sync2;
	assign rise = ~prev[0] & sync2[0];

	always_comb begin
		events = '0;
		events[EV_VBIN]  = fall[0];
		events[EV_VBOUT] = rise;  // End of vertical blank
		events[EV_HBIN]  = fall[1];
		events[EV_SND]   = fall[2];
		events[EV_VDP1]  = fall[3];
		events[EV_SMPC]  = fall[4];
	end

	aEventSingleCycle: assert property (@(posedge CLK) disable iff (!RST_N)
		(events & $past(events)) == '0);

endmodule

//--- src/scuTimers.sv
`timescale 1ns/1ps
`include "scu_cfg.svh"

module scuTimers
	import scuRegPkg::*;
	import scuIrqPkg::*;
(
	input  logic      CLK,
	input  logic      RST_N,
	input  eventT     events,
	input  t0CompareT t0Compare,
	input  t1ReloadT  t1Reload,
	input  t1ModeT    t1Mode,
	output logic      tm0Hit,
	output logic      tm1Hit
);

	t0CompareT              tm0Count;
	logic [`SCU_T1S_W+1:0]  tm1Count;  // Reload times four plus three
	logic                   tm1Armed;
	logic                   enable;
	logic                   lineMode;
	logic                   tm0Match;

	assign enable   = t1Mode[`SCU_T1MD_ENB];
	assign lineMode = t1Mode[`SCU_T1MD_MD];
	assign tm0Match = events[EV_HBIN] && (tm0Count == t0Compare);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tm0Count <= '0;
			tm1Count <= '0;
			tm1Armed <= 1'b0;
			tm0Hit   <= 1'b0;
			tm1Hit   <= 1'b0;
		end else begin
			tm0Hit <= 1'b0;
			tm1Hit <= 1'b0;
			if (enable) begin
				if (events[EV_VBOUT]) begin
					tm0Count <= '0;  // New frame
				end else if (events[EV_HBIN]) begin
					tm0Count <= tm0Count + 1'b1;
				end

				if (tm0Match) begin
					tm0Hit <= 1'b1;
				end

				if (events[EV_HBIN]) begin
					tm1Count <= {t1Reload, 2'b11};
					tm1Armed <= !lineMode || tm0Match;
				end else if (tm1Count != '0) begin
					tm1Count <= tm1Count - 1'b1;
				end else if (tm1Armed) begin
					tm1Hit   <= 1'b1;
					tm1Armed <= 1'b0;  // Once per line
				end
			end
		end
	end

	aHitNeedsEnable: assert property (@(posedge CLK) disable iff (!RST_N)
		(tm0Hit || tm1Hit) |-> $past(enable));

endmodule

//--- src/scuIntCtrl.sv
`timescale 1ns/1ps
`include "scu_cfg.svh"

module scuIntCtrl
	import scuIrqPkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  eventT      events,
	input  logic       tm0Hit,
	input  logic       tm1Hit,
	input  irqVecT     mask,
	input  logic       istWrite,
	input  irqVecT     istData,
	input  logic [1:0] istByteEn,
	input  logic       vecRead,
	input  irqLevelT   ackLevel,
	output irqVecT     status,
	output irqLevelT   irqLevel,
	output vecNumT     vector
);

	irqVecT setVec;
	irqVecT clrVec;
	irqVecT laneVec;
	irqVecT pending;

	function automatic vecNumT levelVector(irqLevelT lvl);
		vecNumT vec;
		case (lvl)
			4'd15:   vec = `SCU_VEC_BASE + 8'd0;
			4'd14:   vec = `SCU_VEC_BASE + 8'd1;
			4'd13:   vec = `SCU_VEC_BASE + 8'd2;
			4'd12:   vec = `SCU_VEC_BASE + 8'd3;
			4'd11:   vec = `SCU_VEC_BASE + 8'd4;
			4'd9:    vec = `SCU_VEC_BASE + 8'd6;
			4'd8:    vec = `SCU_VEC_BASE + 8'd7;
			4'd2:    vec = `SCU_VEC_BASE + 8'd13;
			default: vec = '0;
		endcase
		return vec;
	endfunction

	always_comb begin
		setVec = '0;
		setVec[IRQ_VBIN]  = events[EV_VBIN];
		setVec[IRQ_VBOUT] = events[EV_VBOUT];
		setVec[IRQ_HBIN]  = events[EV_HBIN];
		setVec[IRQ_TM0]   = tm0Hit;
		setVec[IRQ_TM1]   = tm1Hit;
		setVec[IRQ_SND]   = events[EV_SND];
		setVec[IRQ_SMPC]  = events[EV_SMPC];
		setVec[IRQ_VDP1]  = events[EV_VDP1];
	end

	// Zero bits in enabled lanes clear
	assign laneVec = {{(`SCU_IRQ_W/2){istByteEn[1]}}, {(`SCU_IRQ_W/2){istByteEn[0]}}};
	assign clrVec  = istWrite ? (~istData & laneVec) : '0;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			status <= '0;
		end else begin
			status <= (status & ~clrVec) | setVec;  // Set wins over clear
		end
	end

	assign pending = status & ~mask;

	always_comb begin
		if      (pending[IRQ_VBIN])  irqLevel = 4'd15;
		else if (pending[IRQ_VBOUT]) irqLevel = 4'd14;
		else if (pending[IRQ_HBIN])  irqLevel = 4'd13;
		else if (pending[IRQ_TM0])   irqLevel = 4'd12;
		else if (pending[IRQ_TM1])   irqLevel = 4'd11;
		else if (pending[IRQ_SND])   irqLevel = 4'd9;
		else if (pending[IRQ_SMPC])  irqLevel = 4'd8;
		else if (pending[IRQ_VDP1])  irqLevel = 4'd2;
		else                         irqLevel = 4'd0;
	end

	// Vector is latched on acknowledge
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			vector <= '0;
		end else if (vecRead) begin
			vector <= levelVector(ackLevel);
		end
	end

	aLevelHasSource: assert property (@(posedge CLK) disable iff (!RST_N)
		(irqLevel != '0) |-> (|(status & ~mask)));

endmodule

//--- src/scuRegBlock.sv
`timescale 1ns/1ps
`include "scu_cfg.svh"

module scuRegBlock
	import scuRegPkg::*;
	import scuIrqPkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       cs,
	input  logic       wr,
	input  logic       rd,
	input  regOfsT     addr,
	input  byteEnT     byteEn,
	input  dataT       wdata,
	input  irqVecT     status,
	output dataT       rdata,
	output t0CompareT  t0Compare,
	output t1ReloadT   t1Reload,
	output t1ModeT     t1Mode,
	output irqVecT     mask,
	output logic       istWrite,
	output irqVecT     istData,
	output logic [1:0] istByteEn
);

	logic wrEn;
	logic rdEn;

	assign wrEn = cs && wr;
	assign rdEn = cs && rd;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			t0Compare <= '0;
			t1Reload  <= '0;
			t1Mode    <= '0;
			mask      <= `SCU_IMS_RESET;
		end else if (wrEn) begin
			case (addr)
				`SCU_OFS_T0C: begin
					if (byteEn[0]) t0Compare[7:0] <= wdata[7:0];
					if (byteEn[1]) t0Compare[`SCU_T0_W-1:8] <= wdata[`SCU_T0_W-1:8];
				end
				`SCU_OFS_T1S: begin
					if (byteEn[0]) t1Reload[7:0] <= wdata[7:0];
					if (byteEn[1]) t1Reload[`SCU_T1S_W-1:8] <= wdata[`SCU_T1S_W-1:8];
				end
				`SCU_OFS_T1MD: begin
					if (byteEn[0]) t1Mode <= wdata[`SCU_T1MD_W-1:0];
				end
				`SCU_OFS_IMS: begin
					if (byteEn[0]) mask[7:0] <= wdata[7:0];
					if (byteEn[1]) mask[`SCU_IRQ_W-1:8] <= wdata[`SCU_IRQ_W-1:8];
				end
				default: ;
			endcase
		end
	end

	// Status clears are done in the interrupt controller
	assign istWrite  = wrEn && (addr == `SCU_OFS_IST);
	assign istData   = wdata[`SCU_IRQ_W-1:0];
	assign istByteEn = byteEn[1:0];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdata <= '0;
		end else if (rdEn) begin
			rdata <= (addr == `SCU_OFS_IST) ? dataT'(status) : '0;  // Only IST readable
		end
	end

	aNoReadWrite: assert property (@(posedge CLK) disable iff (!RST_N)
		cs |-> !(wr && rd));

endmodule

//--- src/scuIntTimer.sv
`timescale 1ns/1ps

module scuIntTimer
	import scuRegPkg::*;
	import scuIrqPkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     cs,
	input  logic     wr,
	input  logic     rd,
	input  regOfsT   addr,
	input  byteEnT   byteEn,
	input  dataT     wdata,
	output dataT     rdata,
	input  logic     vblankN,
	input  logic     hblankN,
	input  logic     soundReqN,
	input  logic     vdp1ReqN,
	input  logic     smpcReqN,
	output irqLevelT irqLevel,
	input  logic     vecRead,
	input  irqLevelT ackLevel,
	output vecNumT   vector
);

	eventT      events;
	t0CompareT  t0Compare;
	t1ReloadT   t1Reload;
	t1ModeT     t1Mode;
	irqVecT     mask;
	irqVecT     status;
	logic       istWrite;
	irqVecT     istData;
	logic [1:0] istByteEn;
	logic       tm0Hit;
	logic       tm1Hit;

	scuEdgeDetect i_edge (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.vblankN   (vblankN),
		.hblankN   (hblankN),
		.soundReqN (soundReqN),
		.vdp1ReqN  (vdp1ReqN),
		.smpcReqN  (smpcReqN),
		.events    (events)
	);

	scuTimers i_timers (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.events    (events),
		.t0Compare (t0Compare),
		.t1Reload  (t1Reload),
		.t1Mode    (t1Mode),
		.tm0Hit    (tm0Hit),
		.tm1Hit    (tm1Hit)
	);

	scuRegBlock i_regs (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cs        (cs),
		.wr        (wr),
		.rd        (rd),
		.addr      (addr),
		.byteEn    (byteEn),
		.wdata     (wdata),
		.status    (status),
		.rdata     (rdata),
		.t0Compare (t0Compare),
		.t1Reload  (t1Reload),
		.t1Mode    (t1Mode),
		.mask      (mask),
		.istWrite  (istWrite),
		.istData   (istData),
		.istByteEn (istByteEn)
	);

	scuIntCtrl i_intCtrl (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.events    (events),
		.tm0Hit    (tm0Hit),
		.tm1Hit    (tm1Hit),
		.mask      (mask),
		.istWrite  (istWrite),
		.istData   (istData),
		.istByteEn (istByteEn),
		.vecRead   (vecRead),
		.ackLevel  (ackLevel),
		.status    (status),
		.irqLevel  (irqLevel),
		.vector    (vector)
	);

endmodule

//--- verification/scuIntTimerTb.sv
`timescale 1ns/1ps
`include "scu_cfg.svh"

module scuIntTimerTb
	import scuRegPkg::*;
	import scuIrqPkg::*;
();

	localparam int MAX_CYCLES = 3000;  // Whole run stays under 500 cycles
	localparam int LN_VB   = 0;
	localparam int LN_HB   = 1;
	localparam int LN_SND  = 2;
	localparam int LN_VDP1 = 3;
	localparam int LN_SMPC = 4;

	logic     CLK;
	logic     RST_N;
	logic     cs;
	logic     wr;
	logic     rd;
	regOfsT   addr;
	byteEnT   byteEn;
	dataT     wdata;
	dataT     rdata;
	logic [4:0] lineN;  // vblank, hblank, sound, vdp1, smpc
	irqLevelT irqLevel;
	logic     vecRead;
	irqLevelT ackLevel;
	vecNumT   vector;

	irqVecT   modelStatus;
	irqVecT   modelMask;
	irqVecT   expStatus;
	irqLevelT expLevel;
	vecNumT   expVector;
	logic     levelCheck;
	logic     statusCheck;
	logic     vecCheck;
	string    testName;
	integer   seed;
	int       cycles;
	int       compare;
	int       reload;

	scuIntTimer i_dut (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cs        (cs),
		.wr        (wr),
		.rd        (rd),
		.addr      (addr),
		.byteEn    (byteEn),
		.wdata     (wdata),
		.rdata     (rdata),
		.vblankN   (lineN[0]),
		.hblankN   (lineN[1]),
		.soundReqN (lineN[2]),
		.vdp1ReqN  (lineN[3]),
		.smpcReqN  (lineN[4]),
		.irqLevel  (irqLevel),
		.vecRead   (vecRead),
		.ackLevel  (ackLevel),
		.vector    (vector)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: no end of test after %0d cycles", cycles);
			$display(">>> FAIL");
			$fatal(1, "Timeout");
		end
	end

	aLevel: assert property (@(posedge CLK) disable iff (!RST_N)
		levelCheck |-> (irqLevel == expLevel))
	else begin
		$display("Fail %s: expected %0d, actual %0d", testName, expLevel, irqLevel);
		$display(">>> FAIL");
		$fatal(1, "irqLevel mismatch");
	end

	aStatus: assert property (@(posedge CLK) disable iff (!RST_N)
		statusCheck |-> (rdata == {16'h0, expStatus}))
	else begin
		$display("Fail %s: expected %08h, actual %08h", testName, {16'h0, expStatus}, rdata);
		$display(">>> FAIL");
		$fatal(1, "Status read mismatch");
	end

	aVector: assert property (@(posedge CLK) disable iff (!RST_N)
		vecCheck |-> (vector == expVector))
	else begin
		$display("Fail %s: expected %02h, actual %02h", testName, expVector, vector);
		$display(">>> FAIL");
		$fatal(1, "Vector mismatch");
	end

	// Highest pending unmasked source wins
	function automatic irqLevelT levelFor(irqVecT st, irqVecT msk);
		irqVecT p;
		p = st & ~msk;
		if (p[0]) return 4'd15;
		if (p[1]) return 4'd14;
		if (p[2]) return 4'd13;
		if (p[3]) return 4'd12;
		if (p[4]) return 4'd11;
		if (p[6]) return 4'd9;
		if (p[7]) return 4'd8;
		if (p[13]) return 4'd2;
		return 4'd0;
	endfunction

	task automatic regWrite(input regOfsT ofs, input byteEnT be, input dataT data);
		@(posedge CLK);
		cs     <= 1'b1;
		wr     <= 1'b1;
		addr   <= ofs;
		byteEn <= be;
		wdata  <= data;
		@(posedge CLK);
		cs <= 1'b0;
		wr <= 1'b0;
	endtask

	task automatic regRead(input regOfsT ofs);
		@(posedge CLK);
		cs   <= 1'b1;
		rd   <= 1'b1;
		addr <= ofs;
		@(posedge CLK);
		cs <= 1'b0;
		rd <= 1'b0;
	endtask

	// Zero bits clear in both lanes
	task automatic writeStatus(input irqVecT value);
		regWrite(`SCU_OFS_IST, 4'b0011, {16'h0, value});
		modelStatus = modelStatus & value;
	endtask

	task automatic pulseLine(input int idx);
		@(posedge CLK);
		lineN[idx] <= 1'b0;
		repeat (3) @(posedge CLK);
		lineN[idx] <= 1'b1;
	endtask

	task automatic readVector(input irqLevelT lvl);
		@(posedge CLK);
		vecRead  <= 1'b1;
		ackLevel <= lvl;
		@(posedge CLK);
		vecRead <= 1'b0;
	endtask

	task automatic settle();
		repeat (8) @(posedge CLK);
	endtask

	task automatic checkLevel(input string name);
		@(posedge CLK);
		testName   <= name;
		expLevel   <= levelFor(modelStatus, modelMask);
		levelCheck <= 1'b1;
		repeat (2) @(posedge CLK);
		levelCheck <= 1'b0;
	endtask

	task automatic checkStatus(input string name);
		regRead(`SCU_OFS_IST);
		@(posedge CLK);
		testName    <= name;
		expStatus   <= modelStatus;
		statusCheck <= 1'b1;
		repeat (2) @(posedge CLK);
		statusCheck <= 1'b0;
	endtask

	task automatic checkVector(input string name, input vecNumT exp);
		@(posedge CLK);
		testName  <= name;
		expVector <= exp;
		vecCheck  <= 1'b1;
		repeat (2) @(posedge CLK);
		vecCheck <= 1'b0;
	endtask

	initial begin
		RST_N       = 1'b0;
		cs          = 1'b0;
		wr          = 1'b0;
		rd          = 1'b0;
		addr        = '0;
		byteEn      = '0;
		wdata       = '0;
		lineN       = '1;
		vecRead     = 1'b0;
		ackLevel    = '0;
		levelCheck  = 1'b0;
		statusCheck = 1'b0;
		vecCheck    = 1'b0;
		testName    = "";
		cycles      = 0;
		seed        = 29;
		modelStatus = '0;
		modelMask   = 16'hFFFF;
		repeat (5) @(posedge CLK);
		RST_N <= 1'b1;

		checkLevel("reset level");
		checkStatus("reset status");

		// VBlank-in alone then cleared
		regWrite(`SCU_OFS_IMS, 4'b0011, 32'h0000FFFE);
		modelMask = 16'hFFFE;
		@(posedge CLK);
		lineN[LN_VB] <= 1'b0;
		settle();
		modelStatus[0] = 1'b1;
		checkLevel("vblank-in level");
		readVector(4'd15);
		checkVector("vblank-in vector", 8'h40);
		writeStatus(16'hFFFE);
		settle();
		checkLevel("vblank-in clear");
		@(posedge CLK);
		lineN[LN_VB] <= 1'b1;
		settle();
		modelStatus[1] = 1'b1;  // VBlank-out stays masked
		checkStatus("vblank-out masked");

		// HBlank-in over video processor
		regWrite(`SCU_OFS_IMS, 4'b0011, 32'h0000DFFA);
		modelMask = 16'hDFFA;
		pulseLine(LN_HB);
		pulseLine(LN_VDP1);
		settle();
		modelStatus[2]  = 1'b1;
		modelStatus[13] = 1'b1;
		checkLevel("hblank over vdp1");
		writeStatus(16'hFFFB);
		settle();
		checkLevel("vdp1 after clear");
		readVector(4'd2);
		checkVector("vdp1 vector", 8'h4D);
		pulseLine(LN_SND);
		settle();
		modelStatus[6] = 1'b1;
		checkLevel("masked sound level");
		checkStatus("masked sound status");

		// Timer 0 compare with timer 1 firing every line at reload 0
		compare = $unsigned($random(seed)) % 6;
		regWrite(`SCU_OFS_T0C, 4'b0011, compare);
		regWrite(`SCU_OFS_T1MD, 4'b0001, 32'h1);
		pulseLine(LN_VB);
		settle();
		writeStatus(16'h0000);
		for (int i = 0; i <= compare + 1; i++) begin
			pulseLine(LN_HB);
			settle();
			modelStatus[2] = 1'b1;
			modelStatus[4] = 1'b1;
			if (i == compare)
				modelStatus[3] = 1'b1;
			checkStatus($sformatf("timer0 line %0d compare %0d", i, compare));
		end

		// Timer 1 mode 0 with a longer line
		writeStatus(16'h0000);
		reload = 1 + $unsigned($random(seed)) % 8;
		regWrite(`SCU_OFS_T1S, 4'b0011, reload);
		pulseLine(LN_HB);
		repeat (4 * reload + 8) @(posedge CLK);
		modelStatus[2] = 1'b1;
		modelStatus[4] = 1'b1;
		checkStatus($sformatf("timer1 mode 0 reload %0d", reload));

		// Timer 1 mode 1 with compare out of reach
		regWrite(`SCU_OFS_T0C, 4'b0011, 32'h3FF);
		regWrite(`SCU_OFS_T1MD, 4'b0001, 32'h3);
		writeStatus(16'h0000);
		pulseLine(LN_HB);
		repeat (4 * reload + 8) @(posedge CLK);
		modelStatus[2] = 1'b1;
		checkStatus("timer1 mode 1");

		// Low mask lane only
		regWrite(`SCU_OFS_T1MD, 4'b0001, 32'h0);
		regWrite(`SCU_OFS_IMS, 4'b0011, 32'h0000FFFF);
		regWrite(`SCU_OFS_IMS, 4'b0001, 32'h00000000);
		modelMask = 16'hFF00;
		writeStatus(16'h0000);
		pulseLine(LN_VDP1);
		settle();
		modelStatus[13] = 1'b1;
		checkLevel("lane 1 keeps vdp1 masked");
		checkStatus("vdp1 status");
		pulseLine(LN_SND);
		settle();
		modelStatus[6] = 1'b1;
		checkLevel("lane 0 unmasks sound");
		readVector(4'd9);
		checkVector("sound vector", 8'h46);

		// System manager below sound
		writeStatus(16'hFFBF);
		pulseLine(LN_SMPC);
		settle();
		modelStatus[7] = 1'b1;
		checkLevel("smpc level");
		readVector(4'd8);
		checkVector("smpc vector", 8'h47);
		checkStatus("smpc status");

		settle();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
src/scuRegPkg.sv
src/scuIrqPkg.sv
src/scuEdgeDetect.sv
src/scuTimers.sv
src/scuIntCtrl.sv
src/scuRegBlock.sv
src/scuIntTimer.sv
verification/scuIntTimerTb.sv

//--- Makefile
TOP := scuIntTimerTb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir $(OBJ) -f verilog.f

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
